// ==== rtl/periph_pkg.sv ====
// --------------------
// Word addresses are A15:1 of the peripheral space
// Only LIR, PICR1 and timer 0 registers exist here
// --------------------
`default_nettype none

package periph_pkg;

    // Interrupt priority level, 0 means no request
    typedef logic [2:0] ipl_t;

    // One peripheral bus access, strobes and write are active high
    typedef struct packed {
        logic        sel;    // Peripheral space select
        logic [14:0] addr;   // Word address A15:1
        logic        lds;    // Lower byte D7:0
        logic        uds;    // Upper byte D15:8
        logic        write;
        logic [15:0] wdata;
    } bus_req_t;

    // Levels of the on-chip interrupt sources
    typedef struct packed {
        ipl_t int1_ipl;
        ipl_t int2_ipl;
        ipl_t timer_ipl;
    } irq_cfg_t;

    // Register word addresses
    localparam logic [14:0] LIR_ADDR   = 15'h0800;
    localparam logic [14:0] PICR1_ADDR = 15'h1022;
    localparam logic [14:0] TIMER_BASE = 15'h1010;
    localparam logic [14:0] TIMER_LAST = 15'h1014;

    // Timer register offsets on A3:1
    localparam logic [2:0] TMR_STATUS = 3'd0;
    localparam logic [2:0] TMR_RELOAD = 3'd1;
    localparam logic [2:0] TMR_COUNT  = 3'd2;

    // On-chip vectors are this base plus the acknowledged level
    localparam logic [15:0] VECTOR_BASE = 16'd56;

endpackage

`default_nettype wire

// ==== rtl/periph_regs.sv ====
// --------------------
// Reads are combinational with no wait state
// Writes take effect on the next clock edge
// Unmapped addresses read as zero
// --------------------
`default_nettype none

module periph_regs import periph_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire bus_req_t    bus,
    input  wire logic [15:0] count,
    input  wire logic        ovf,
    input  wire logic        vector_valid,
    input  wire logic [15:0] vector,
    output irq_cfg_t         irq_cfg,
    output logic      [15:0] reload_value,
    output logic             count_load,
    output logic             ovf_clear,
    output logic      [15:0] rdata
);

    logic       lir_cs;
    logic       picr1_cs;
    logic       timer_cs;
    logic [2:0] tmr_offset;
    logic       wr_any;

    assign lir_cs   = bus.sel && (bus.addr == LIR_ADDR);
    assign picr1_cs = bus.sel && (bus.addr == PICR1_ADDR);
    assign timer_cs = bus.sel && (bus.addr >= TIMER_BASE) && (bus.addr <= TIMER_LAST);

    assign tmr_offset = bus.addr[2:0];   // A3:1
    assign wr_any     = bus.write && (bus.lds || bus.uds);

    // Timer commands, single cycle since the bus holds one cycle per access
    assign count_load = timer_cs && wr_any && (tmr_offset == TMR_COUNT);
    assign ovf_clear  = timer_cs && bus.write && bus.uds && (tmr_offset == TMR_STATUS)
                        && bus.wdata[15];

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_cfg      <= '0;
            reload_value <= '0;
        end else begin
            // Level fields live in the lower byte only
            if (lir_cs && bus.write && bus.lds) begin
                irq_cfg.int1_ipl <= bus.wdata[6:4];
                irq_cfg.int2_ipl <= bus.wdata[2:0];
            end

            if (picr1_cs && bus.write && bus.lds) begin
                irq_cfg.timer_ipl <= bus.wdata[2:0];
            end

            if (timer_cs && bus.write && (tmr_offset == TMR_RELOAD)) begin
                if (bus.uds) begin
                    reload_value[15:8] <= bus.wdata[15:8];
                end
                if (bus.lds) begin
                    reload_value[7:0] <= bus.wdata[7:0];
                end
            end
        end
    end

    always_comb begin
        rdata = '0;

        if (lir_cs) begin
            // Same byte on both halves
            rdata = {2{1'b0, irq_cfg.int1_ipl, 1'b0, irq_cfg.int2_ipl}};
        end else if (picr1_cs) begin
            rdata = {2{5'b0, irq_cfg.timer_ipl}};
        end else if (timer_cs) begin
            case (tmr_offset)
                TMR_STATUS: rdata = {ovf, 15'b0};   // Overflow flag in bit 15
                TMR_RELOAD: rdata = reload_value;
                TMR_COUNT:  rdata = count;
                default:    rdata = '0;
            endcase
        end

        // Acknowledge cycle for an on-chip source returns its vector
        if (vector_valid) begin
            rdata = vector;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timer0.sv ====
// --------------------
// Counts up once per TICKS_PER_COUNT clocks
// Overflow reload wins over a software load
// --------------------
`default_nettype none

module timer0 #(
    parameter logic [7:0] TICKS_PER_COUNT = 8'd192
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [15:0] reload_value,
    input  wire logic        count_load,
    input  wire logic [15:0] load_data,
    input  wire logic        ovf_clear,
    output logic      [15:0] count,
    output logic             ovf
);

    logic [7:0] prescale;
    logic       at_top;

    assign at_top = (count == 16'hFFFF);

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            prescale <= '0;
        end else if (at_top) begin
            count    <= reload_value;
            prescale <= '0;
        end else if (count_load) begin
            count    <= load_data;
            prescale <= '0;   // Fresh period after a load
        end else if (prescale == TICKS_PER_COUNT - 8'd1) begin
            count    <= count + 16'd1;
            prescale <= '0;
        end else begin
            prescale <= prescale + 8'd1;
        end
    end

    // Sticky flag, set has priority over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            ovf <= 1'b0;
        end else if (at_top) begin
            ovf <= 1'b1;
        end else if (ovf_clear) begin
            ovf <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/irq_priority.sv ====
// --------------------
// Later sources in the chain override earlier ones
// On-chip sources with level 0 are disabled
// autovector lags ack_level by one clock
// --------------------
`default_nettype none

module irq_priority import periph_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire irq_cfg_t irq_cfg,
    input  wire logic     ovf,
    input  wire logic     in2,
    input  wire logic     in4,
    input  wire logic     in5,
    input  wire logic     int1,
    input  wire logic     int2,
    input  wire logic     av,
    input  wire logic     iack_cycle,
    input  wire ipl_t     ack_level,
    output ipl_t          ipl,
    output logic          autovector,
    output logic          iack2,
    output logic          iack4,
    output logic          iack5,
    output logic          vector_valid,
    output logic   [15:0] vector
);

    logic [7:0] av_table;   // Autovector flag per level
    logic       on_chip;

    always_comb begin
        ipl      = '0;
        av_table = 8'hFF;
        on_chip  = 1'b0;

        // External decoded levels
        if (in2) begin
            ipl = 3'd2;
        end
        if (in4) begin
            ipl         = 3'd4;
            av_table[4] = av;   // Device chooses vectored or auto
        end
        if (in5) begin
            ipl = 3'd5;
        end

        // On-chip sources supply their own vector
        if (int1 && (irq_cfg.int1_ipl != 3'd0)) begin
            ipl                        = irq_cfg.int1_ipl;
            av_table[irq_cfg.int1_ipl] = 1'b0;
            on_chip                    = 1'b1;
        end
        if (int2 && (irq_cfg.int2_ipl != 3'd0)) begin
            ipl                        = irq_cfg.int2_ipl;
            av_table[irq_cfg.int2_ipl] = 1'b0;
            on_chip                    = 1'b1;
        end
        if (ovf && (irq_cfg.timer_ipl != 3'd0)) begin
            ipl                         = irq_cfg.timer_ipl;
            av_table[irq_cfg.timer_ipl] = 1'b0;
            on_chip                     = 1'b1;
        end
    end

    assign iack2 = in2 && iack_cycle && (ack_level == 3'd2);
    assign iack4 = in4 && iack_cycle && (ack_level == 3'd4);
    assign iack5 = in5 && iack_cycle && (ack_level == 3'd5);

    assign vector_valid = iack_cycle && on_chip;
    assign vector       = VECTOR_BASE + {13'b0, ack_level};

    always_ff @(posedge clk) begin
        if (reset) begin
            autovector <= 1'b0;
        end else begin
            autovector <= av_table[ack_level];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scc_periph_top.sv ====
// --------------------
// Acknowledged level is taken from bus.addr[2:0]
// TICKS_PER_COUNT sets the timer prescale
// --------------------
`default_nettype none

module scc_periph_top import periph_pkg::*; #(
    parameter logic [7:0] TICKS_PER_COUNT = 8'd192
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire bus_req_t bus,
    input  wire logic     iack_cycle,
    input  wire logic     in2,
    input  wire logic     in4,
    input  wire logic     in5,
    input  wire logic     int1,
    input  wire logic     int2,
    input  wire logic     av,
    output logic   [15:0] rdata,
    output ipl_t          ipl,
    output logic          autovector,
    output logic          iack2,
    output logic          iack4,
    output logic          iack5
);

    irq_cfg_t    irq_cfg;
    logic [15:0] reload_value;
    logic        count_load;
    logic        ovf_clear;
    logic [15:0] count;
    logic        ovf;
    logic        vector_valid;
    logic [15:0] vector;

    periph_regs regs0 (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .count        (count),
        .ovf          (ovf),
        .vector_valid (vector_valid),
        .vector       (vector),
        .irq_cfg      (irq_cfg),
        .reload_value (reload_value),
        .count_load   (count_load),
        .ovf_clear    (ovf_clear),
        .rdata        (rdata)
    );

    timer0 #(
        .TICKS_PER_COUNT (TICKS_PER_COUNT)
    ) tmr0 (
        .clk          (clk),
        .reset        (reset),
        .reload_value (reload_value),
        .count_load   (count_load),
        .load_data    (bus.wdata),   // Load value straight from the bus
        .ovf_clear    (ovf_clear),
        .count        (count),
        .ovf          (ovf)
    );

    irq_priority irq0 (
        .clk          (clk),
        .reset        (reset),
        .irq_cfg      (irq_cfg),
        .ovf          (ovf),
        .in2          (in2),
        .in4          (in4),
        .in5          (in5),
        .int1         (int1),
        .int2         (int2),
        .av           (av),
        .iack_cycle   (iack_cycle),
        .ack_level    (bus.addr[2:0]),   // A3:1 during acknowledge
        .ipl          (ipl),
        .autovector   (autovector),
        .iack2        (iack2),
        .iack4        (iack4),
        .iack5        (iack5),
        .vector_valid (vector_valid),
        .vector       (vector)
    );

endmodule

`default_nettype wire

// ==== verification/tb_scc_periph.sv ====
// --------------------
// Runs the DUT with TICKS_PER_COUNT set to 4
// Inputs change on the rising edge, outputs are sampled on the falling edge
// --------------------
`default_nettype none

module tb_scc_periph import periph_pkg::*; ();

    // External and on-chip interrupt request lines
    typedef struct packed {
        logic in2;
        logic in4;
        logic in5;
        logic int1;
        logic int2;
    } src_t;

    localparam int          POLL_LIMIT  = 64;
    localparam logic [14:0] STATUS_ADDR = TIMER_BASE + {12'b0, TMR_STATUS};
    localparam logic [14:0] RELOAD_ADDR = TIMER_BASE + {12'b0, TMR_RELOAD};
    localparam logic [14:0] COUNT_ADDR  = TIMER_BASE + {12'b0, TMR_COUNT};

    logic        clk;
    logic        reset;
    bus_req_t    bus;
    logic        iack_cycle;
    src_t        src;
    logic        av;
    logic [15:0] rdata;
    ipl_t        ipl;
    logic        autovector;
    logic        iack2;
    logic        iack4;
    logic        iack5;
    int          errors;
    int          timeouts;
    ipl_t        l1;
    ipl_t        l2;
    ipl_t        lt;
    ipl_t        lvl;
    logic [31:0] rnd;
    logic [15:0] value;
    logic        av_expected;

    scc_periph_top #(
        .TICKS_PER_COUNT (8'd4)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .iack_cycle (iack_cycle),
        .in2        (src.in2),
        .in4        (src.in4),
        .in5        (src.in5),
        .int1       (src.int1),
        .int2       (src.int2),
        .av         (av),
        .rdata      (rdata),
        .ipl        (ipl),
        .autovector (autovector),
        .iack2      (iack2),
        .iack4      (iack4),
        .iack5      (iack5)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic bus_req_t bus_request(input logic sel, input logic [14:0] addr,
                                             input logic lds, input logic uds,
                                             input logic write, input logic [15:0] wdata);
        bus_req_t req;
        req.sel   = sel;
        req.addr  = addr;
        req.lds   = lds;
        req.uds   = uds;
        req.write = write;
        req.wdata = wdata;
        return req;
    endfunction

    // Ascending precedence, later sources replace earlier ones
    function automatic ipl_t expected_level(input src_t s, input ipl_t lv1, input ipl_t lv2,
                                            input ipl_t lvt, input logic ovf_on);
        ipl_t level;
        level = 3'd0;
        if (s.in2) level = 3'd2;
        if (s.in4) level = 3'd4;
        if (s.in5) level = 3'd5;
        if (s.int1 && lv1 != 3'd0) level = lv1;
        if (s.int2 && lv2 != 3'd0) level = lv2;
        if (ovf_on && lvt != 3'd0) level = lvt;
        return level;
    endfunction

    // Timer flag is clear whenever this is used
    function automatic logic expected_autovector(input src_t s, input ipl_t level,
                                                 input logic av_in);
        logic flag;
        flag = 1'b1;
        if (level == 3'd4 && s.in4) flag = av_in;
        if (s.int1 && l1 != 3'd0 && l1 == level) flag = 1'b0;
        if (s.int2 && l2 != 3'd0 && l2 == level) flag = 1'b0;
        return flag;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [14:0] addr, input logic [15:0] data,
                             input logic lds, input logic uds);
        @(posedge clk);
        bus <= bus_request(1'b1, addr, lds, uds, 1'b1, data);
        @(posedge clk);
        bus <= bus_request(1'b0, 15'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    endtask

    task automatic read_reg(input logic [14:0] addr, output logic [15:0] data);
        @(posedge clk);
        bus <= bus_request(1'b1, addr, 1'b1, 1'b1, 1'b0, 16'h0);
        @(negedge clk);
        data = rdata;
    endtask

    // Loads a count just below the top and polls for the flag
    task automatic run_to_overflow();
        logic [15:0] status;
        int          polls;
        logic        found;
        write_reg(RELOAD_ADDR, 16'h1234, 1'b1, 1'b1);
        write_reg(COUNT_ADDR, 16'hFFFE, 1'b1, 1'b1);
        found = 1'b0;
        polls = 0;
        while (!found && polls < POLL_LIMIT) begin
            read_reg(STATUS_ADDR, status);
            found = status[15];
            polls++;
        end
        if (!found) begin
            timeouts++;
            $display("Timeout: overflow flag never set while polling the timer status");
        end
    endtask

    initial begin
        rnd = $urandom(53561);
        errors = 0;
        timeouts = 0;
        reset <= 1'b1;
        bus <= bus_request(1'b0, 15'h0, 1'b0, 1'b0, 1'b0, 16'h0);
        iack_cycle <= 1'b0;
        src <= '0;
        av <= 1'b0;
        l1 = 3'd0;
        l2 = 3'd0;
        lt = 3'd0;

        // Reset state
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("reset_ipl", 16'h0, {13'b0, ipl});
        check_value("reset_autovector", 16'h0, {15'b0, autovector});
        @(posedge clk);
        reset <= 1'b0;
        read_reg(LIR_ADDR, value);
        check_value("reset_lir", 16'h0, value);
        read_reg(PICR1_ADDR, value);
        check_value("reset_picr1", 16'h0, value);
        read_reg(STATUS_ADDR, value);
        check_value("reset_status", 16'h0, value);

        // Register read-back, mirrored byte layout
        rnd = $urandom;
        l1 = rnd[2:0];
        l2 = rnd[6:4];
        lt = rnd[10:8];
        write_reg(LIR_ADDR, {8'h00, 1'b0, l1, 1'b0, l2}, 1'b1, 1'b1);
        read_reg(LIR_ADDR, value);
        check_value("lir_readback", {2{1'b0, l1, 1'b0, l2}}, value);
        write_reg(PICR1_ADDR, {13'b0, lt}, 1'b1, 1'b0);
        read_reg(PICR1_ADDR, value);
        check_value("picr1_readback", {2{5'b0, lt}}, value);
        write_reg(RELOAD_ADDR, 16'hA55A, 1'b1, 1'b1);
        write_reg(RELOAD_ADDR, rnd[31:16], 1'b0, 1'b1);   // Upper byte only
        read_reg(RELOAD_ADDR, value);
        check_value("reload_upper_byte", {rnd[31:24], 8'h5A}, value);

        // Priority with random sources and LIR levels
        for (int i = 0; i < 24; i++) begin
            rnd = $urandom;
            l1 = rnd[2:0];
            l2 = rnd[6:4];
            write_reg(LIR_ADDR, {8'h00, 1'b0, l1, 1'b0, l2}, 1'b1, 1'b0);
            @(posedge clk);
            src <= rnd[12:8];
            @(negedge clk);
            check_value("priority_ipl", {13'b0, expected_level(src, l1, l2, lt, 1'b0)},
                        {13'b0, ipl});
        end

        // Acknowledge cycles, every level four times
        for (int i = 0; i < 32; i++) begin
            rnd = $urandom;
            lvl = i[2:0];
            if (lvl == 3'd0) begin
                l1 = rnd[18:16];
                l2 = rnd[22:20];
                write_reg(LIR_ADDR, {8'h00, 1'b0, l1, 1'b0, l2}, 1'b1, 1'b0);
            end
            @(posedge clk);
            src <= rnd[4:0];
            av <= rnd[5];
            iack_cycle <= (rnd[7:6] != 2'b00);   // Mostly inside an acknowledge
            bus <= bus_request(1'b0, {12'b0, lvl}, 1'b0, 1'b0, 1'b0, 16'h0);
            @(negedge clk);
            check_value("iack2", {15'b0, iack_cycle && src.in2 && lvl == 3'd2},
                        {15'b0, iack2});
            check_value("iack4", {15'b0, iack_cycle && src.in4 && lvl == 3'd4},
                        {15'b0, iack4});
            check_value("iack5", {15'b0, iack_cycle && src.in5 && lvl == 3'd5},
                        {15'b0, iack5});
            if (iack_cycle && ((src.int1 && l1 != 3'd0) || (src.int2 && l2 != 3'd0))) begin
                check_value("onchip_vector", 16'd56 + {13'b0, lvl}, rdata);
            end else begin
                check_value("idle_rdata", 16'h0, rdata);   // No select and no vector
            end
            av_expected = expected_autovector(src, lvl, av);
            @(posedge clk);
            src <= '0;   // Registered flag must keep the old inputs
            av <= ~av;
            @(negedge clk);
            check_value("autovector", {15'b0, av_expected}, {15'b0, autovector});
        end
        @(posedge clk);
        iack_cycle <= 1'b0;
        src <= '0;
        bus <= bus_request(1'b0, 15'h0, 1'b0, 1'b0, 1'b0, 16'h0);

        // Timer overflow, reload and flag clear
        run_to_overflow();
        read_reg(COUNT_ADDR, value);
        assert (value >= 16'h1234 && value < 16'h1236) else begin
            errors++;
            $display("Error timer_reload: expected 1234 to 1235, actual %h", value);
        end
        write_reg(STATUS_ADDR, 16'h8000, 1'b0, 1'b1);
        read_reg(STATUS_ADDR, value);
        check_value("ovf_clear", 16'h0, value);

        // Timer interrupt outranks every other source
        rnd = $urandom;
        lt = (rnd[2:0] == 3'd0) ? 3'd7 : rnd[2:0];
        l1 = rnd[6:4];
        l2 = rnd[10:8];
        write_reg(PICR1_ADDR, {13'b0, lt}, 1'b1, 1'b0);
        write_reg(LIR_ADDR, {8'h00, 1'b0, l1, 1'b0, l2}, 1'b1, 1'b0);
        @(posedge clk);
        src <= 5'b11111;
        run_to_overflow();
        @(negedge clk);
        check_value("timer_ipl", {13'b0, expected_level(src, l1, l2, lt, 1'b1)},
                    {13'b0, ipl});
        write_reg(STATUS_ADDR, 16'h8000, 1'b0, 1'b1);
        @(negedge clk);
        check_value("timer_ipl_cleared", {13'b0, expected_level(src, l1, l2, lt, 1'b0)},
                    {13'b0, ipl});

        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/periph_pkg.sv
rtl/periph_regs.sv
rtl/timer0.sv
rtl/irq_priority.sv
rtl/scc_periph_top.sv
verification/tb_scc_periph.sv

// ==== Makefile ====
TOP := tb_scc_periph

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
